//--- regExec.f
hdl/regExecPkg.sv
hdl/regFile.sv
hdl/instrDecode.sv
hdl/aluUnit.sv
hdl/regExecTop.sv
test/regExecTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= regExecTb
RTL_TOP   ?= regExecTop
FILELIST  ?= regExec.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= ** PASS **

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out=$$(./$(BUILD_DIR)/$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF -- "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- test/regExecTb.sv
`timescale 1ns/100ps
`default_nettype none

module regExecTb;

    import regExecPkg::*;

    localparam int CYCLE_LIMIT = 2000;    // Stimulus runs about 350 cycles

    logic        clk = 1'b0;
    logic        rst;
    logic        instrValid;
    instrWord_t  instr;
    logic        resultValid;
    word_t       result;
    regAddr_t    resultDest;
    logic        illegal;

    word_t       model [REG_COUNT];    // Reference register contents
    logic        pendValid;
    logic        pendIllegal;
    word_t       pendResult;
    regAddr_t    pendDest;
    string       pendName;
    logic        chkValid;
    logic        chkIllegal;
    word_t       chkResult;
    regAddr_t    chkDest;
    string       chkName;
    logic [31:0] lcgState;
    int          errorCount;
    int          issuedCount;
    int          cycleCount = 0;

    regExecTop DUT (
        .clk         (clk),
        .rst         (rst),
        .instrValid  (instrValid),
        .instr       (instr),
        .resultValid (resultValid),
        .result      (result),
        .resultDest  (resultDest),
        .illegal     (illegal)
    );

    always #2 clk = ~clk;

    // Expectations line up with the DUT report registers
    always @(posedge clk) begin
        if (rst) begin
            chkValid   <= 1'b0;
            chkIllegal <= 1'b0;
        end else begin
            chkValid   <= pendValid;
            chkIllegal <= pendIllegal;
            chkResult  <= pendResult;
            chkDest    <= pendDest;
            chkName    <= pendName;
        end
    end

    // Sampled on the falling edge once outputs have settled
    assert property (@(negedge clk) disable iff (rst) resultValid == chkValid)
        else begin
            errorCount++;
            $display("[FAIL] %s resultValid expected %0b actual %0b", chkName, chkValid,
                     resultValid);
        end
    assert property (@(negedge clk) disable iff (rst) illegal == chkIllegal)
        else begin
            errorCount++;
            $display("[FAIL] %s illegal expected %0b actual %0b", chkName, chkIllegal, illegal);
        end
    assert property (@(negedge clk) disable iff (rst) chkValid |-> result == chkResult)
        else begin
            errorCount++;
            $display("[FAIL] %s result expected %h actual %h", chkName, chkResult, result);
        end
    assert property (@(negedge clk) disable iff (rst) chkValid |-> resultDest == chkDest)
        else begin
            errorCount++;
            $display("[FAIL] %s resultDest expected %0d actual %0d", chkName, chkDest,
                     resultDest);
        end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("** FAIL **");
            $finish;
        end
    end

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic logic [31:0] rWord(logic [5:0] fn, regAddr_t rd, regAddr_t rs,
                                          regAddr_t rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iWord(logic [5:0] op, regAddr_t rt, regAddr_t rs,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [5:0] pickFunct(logic [2:0] sel);
        case (sel)
            3'd0:    return FN_ADD;
            3'd1:    return FN_SUB;
            3'd2:    return FN_AND;
            3'd3:    return FN_OR;
            3'd4:    return FN_XOR;
            default: return FN_SLT;
        endcase
    endfunction

    function automatic logic [5:0] pickImmOp(logic [1:0] sel);
        case (sel)
            2'd0:    return OP_ADDI;
            2'd1:    return OP_ANDI;
            2'd2:    return OP_ORI;
            default: return OP_LUI;
        endcase
    endfunction

    function automatic word_t modelRead(regAddr_t addr);
        if (addr == 5'd0) begin
            return 32'd0;
        end
        if (addr == 5'd1) begin
            return 32'd1;
        end
        return model[addr];
    endfunction

    // Drives one word and predicts its report from the ISA rules
    task automatic issue(input logic [31:0] raw, input string name);
        word_t       a;
        word_t       b;
        word_t       res;
        logic        bad;
        regAddr_t    dst;
        logic [15:0] imm;
        a   = modelRead(raw[25:21]);
        b   = modelRead(raw[20:16]);
        imm = raw[15:0];
        res = '0;
        bad = 1'b0;
        dst = raw[20:16];
        case (raw[31:26])
            OP_RTYPE: begin
                dst = raw[15:11];
                case (raw[5:0])
                    FN_ADD:  res = a + b;
                    FN_SUB:  res = a - b;
                    FN_AND:  res = a & b;
                    FN_OR:   res = a | b;
                    FN_XOR:  res = a ^ b;
                    FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: bad = 1'b1;
                endcase
            end
            OP_ADDI: res = a + {{16{imm[15]}}, imm};
            OP_ANDI: res = a & {16'h0000, imm};
            OP_ORI:  res = a | {16'h0000, imm};
            OP_LUI:  res = {imm, 16'h0000};
            default: bad = 1'b1;
        endcase
        instr       = raw;
        instrValid  = 1'b1;
        pendValid   = !bad;
        pendIllegal = bad;
        pendResult  = res;
        pendDest    = dst;
        pendName    = name;
        if (!bad && dst != 5'd0 && dst != 5'd1) begin
            model[dst] = res;
        end
        issuedCount++;
        @(posedge clk);
        #0.5;
    endtask

    task automatic idle();
        instrValid  = 1'b0;
        instr       = nextRand();    // Junk on the bus must be ignored
        pendValid   = 1'b0;
        pendIllegal = 1'b0;
        @(posedge clk);
        #0.5;
    endtask

    // OR into r0 reports each register without changing any
    task automatic readBack(input string name);
        for (int k = 0; k < REG_COUNT; k++) begin
            issue(rWord(FN_OR, 5'd0, regAddr_t'(k), 5'd0), name);
        end
    endtask

    initial begin
        logic [31:0] rv;
        logic [31:0] raw;
        logic [15:0] imm;
        rst         = 1'b1;
        instrValid  = 1'b0;
        instr       = '0;
        pendValid   = 1'b0;
        pendIllegal = 1'b0;
        pendResult  = '0;
        pendDest    = '0;
        pendName    = "reset";
        lcgState    = 32'h7c0a;
        errorCount  = 0;
        issuedCount = 0;
        for (int k = 0; k < REG_COUNT; k++) begin
            model[k] = '0;
        end
        repeat (4) @(posedge clk);
        #0.5;
        rst = 1'b0;

        issue(rWord(FN_ADD, 5'd2, 5'd1, 5'd0), "addAfterReset");
        issue(rWord(FN_OR, 5'd3, 5'd2, 5'd0), "orReadsR2");
        idle();

        for (int k = 2; k < REG_COUNT; k++) begin    // Load every register
            rv  = nextRand();
            imm = rv[31:16];
            issue(iWord(OP_LUI, regAddr_t'(k), rv[12:8], imm), "seedLui");
            rv = nextRand();
            issue(iWord(OP_ORI, regAddr_t'(k), regAddr_t'(k), rv[31:16]), "seedOri");
        end

        repeat (100) begin
            rv = nextRand();
            issue(rWord(pickFunct(rv[31:29]), rv[28:24], rv[23:19], rv[18:14]), "randomRType");
        end

        for (int n = 0; n < 60; n++) begin
            rv      = nextRand();
            raw     = nextRand();
            imm     = raw[31:16];
            imm[15] = n[0];    // Half of them negative
            issue(iWord(pickImmOp(rv[31:30]), rv[29:25], rv[24:20], imm), "randomIType");
        end
        idle();

        issue(rWord(FN_ADD, 5'd0, 5'd5, 5'd6), "writeR0");
        issue(iWord(OP_ORI, 5'd1, 5'd7, 16'hffff), "writeR1");
        issue(iWord(OP_LUI, 5'd0, 5'd0, 16'h8000), "luiR0");
        issue(iWord(OP_ADDI, 5'd1, 5'd1, 16'hfffe), "addiR1");
        readBack("constRegs");

        issue(iWord(OP_ADDI, 5'd10, 5'd0, 16'h0003), "chainStart");
        repeat (6) begin
            rv = nextRand();
            issue(iWord(OP_ADDI, 5'd10, 5'd10, rv[31:16]), "chainAddi");
            issue(rWord(FN_ADD, 5'd11, 5'd11, 5'd10), "chainAdd");
            issue(rWord(FN_SLT, 5'd12, 5'd11, 5'd10), "chainSlt");
        end
        idle();

        for (int n = 0; n < 8; n++) begin
            rv  = nextRand();
            raw = nextRand();
            if (n[0] == 1'b0) begin
                case (rv[31:30])
                    2'd0:    raw[31:26] = 6'h02;
                    2'd1:    raw[31:26] = 6'h04;
                    2'd2:    raw[31:26] = 6'h23;
                    default: raw[31:26] = 6'h2b;
                endcase
                issue(raw, "badOpcode");
            end else begin
                raw[31:26] = OP_RTYPE;
                case (rv[31:30])
                    2'd0:    raw[5:0] = 6'h00;
                    2'd1:    raw[5:0] = 6'h08;
                    2'd2:    raw[5:0] = 6'h21;
                    default: raw[5:0] = 6'h27;
                endcase
                issue(raw, "badFunct");
            end
        end
        readBack("afterIllegal");
        repeat (3) idle();

        $display("Issued %0d instructions, %0d errors", issuedCount, errorCount);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/regExecTop.sv
`timescale 1ns/100ps
`default_nettype none

module regExecTop (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   instrValid,
    input  regExecPkg::instrWord_t instr,
    output logic                   resultValid,
    output regExecPkg::word_t      result,
    output regExecPkg::regAddr_t   resultDest,
    output logic                   illegal
);

    import regExecPkg::*;

    ctrl_t ctrl;
    word_t readData1;
    word_t readData2;
    word_t aluResult;
    logic  regWrite;

    assign regWrite = instrValid & ctrl.writeEn;    // Lands at the accepting edge

    regFile uRegFile (
        .clk       (clk),
        .rst       (rst),
        .readReg1  (instr.r.rs),
        .readReg2  (instr.r.rt),
        .writeReg  (ctrl.dest),
        .writeData (aluResult),
        .regWrite  (regWrite),
        .readData1 (readData1),
        .readData2 (readData2)
    );

    instrDecode uInstrDecode (
        .instr (instr),
        .ctrl  (ctrl)
    );

    aluUnit uAluUnit (
        .operandA  (readData1),
        .operandB  (readData2),
        .ctrl      (ctrl),
        .aluResult (aluResult)
    );

    // Report pulses, one cycle after the strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
            illegal     <= 1'b0;
        end else begin
            resultValid <= instrValid & ~ctrl.illegal;
            illegal     <= instrValid & ctrl.illegal;
        end
    end

    // Result payload
    always_ff @(posedge clk) begin
        if (instrValid) begin
            result     <= aluResult;
            resultDest <= ctrl.dest;    // Reported even for r0 and r1
        end
    end

endmodule

`default_nettype wire

//--- hdl/aluUnit.sv
`timescale 1ns/100ps
`default_nettype none

module aluUnit (
    input  regExecPkg::word_t operandA,
    input  regExecPkg::word_t operandB,
    input  regExecPkg::ctrl_t ctrl,
    output regExecPkg::word_t aluResult
);

    import regExecPkg::*;

    word_t opB;
    logic  lessThan;

    assign opB = ctrl.useImm ? ctrl.imm : operandB;    // Immediate or rt
    assign lessThan = $signed(operandA) < $signed(opB);

    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD: aluResult = operandA + opB;
            ALU_SUB: aluResult = operandA - opB;
            ALU_AND: aluResult = operandA & opB;
            ALU_OR:  aluResult = operandA | opB;
            ALU_XOR: aluResult = operandA ^ opB;
            ALU_SLT: aluResult = {31'd0, lessThan};     // Signed compare
            ALU_LUI: aluResult = {opB[15:0], 16'h0000};
            default: aluResult = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/instrDecode.sv
`timescale 1ns/100ps
`default_nettype none

module instrDecode (
    input  regExecPkg::instrWord_t instr,
    output regExecPkg::ctrl_t      ctrl
);

    import regExecPkg::*;

    always_comb begin
        ctrl.aluOp   = ALU_ADD;
        ctrl.useImm  = 1'b0;
        ctrl.imm     = '0;
        ctrl.dest    = instr.i.rt;       // I-type writes rt
        ctrl.writeEn = 1'b1;
        ctrl.illegal = 1'b0;

        case (instr.r.op)
            OP_RTYPE: begin
                ctrl.dest = instr.r.rd;    // R-type writes rd
                case (instr.r.funct)
                    FN_ADD: ctrl.aluOp = ALU_ADD;
                    FN_SUB: ctrl.aluOp = ALU_SUB;
                    FN_AND: ctrl.aluOp = ALU_AND;
                    FN_OR:  ctrl.aluOp = ALU_OR;
                    FN_XOR: ctrl.aluOp = ALU_XOR;
                    FN_SLT: ctrl.aluOp = ALU_SLT;
                    default: begin
                        ctrl.illegal = 1'b1;
                    end
                endcase
            end
            OP_ADDI: begin
                ctrl.aluOp  = ALU_ADD;
                ctrl.useImm = 1'b1;
                ctrl.imm    = {{16{instr.i.imm[15]}}, instr.i.imm};    // Sign extend
            end
            OP_ANDI: begin
                ctrl.aluOp  = ALU_AND;
                ctrl.useImm = 1'b1;
                ctrl.imm    = {16'h0000, instr.i.imm};    // Zero extend
            end
            OP_ORI: begin
                ctrl.aluOp  = ALU_OR;
                ctrl.useImm = 1'b1;
                ctrl.imm    = {16'h0000, instr.i.imm};
            end
            OP_LUI: begin
                ctrl.aluOp  = ALU_LUI;
                ctrl.useImm = 1'b1;
                ctrl.imm    = {16'h0000, instr.i.imm};    // ALU moves it up
            end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase

        // Illegal words never touch the register file
        if (ctrl.illegal) begin
            ctrl.writeEn = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/regFile.sv
`timescale 1ns/100ps
`default_nettype none

module regFile (
    input  logic                 clk,
    input  logic                 rst,
    input  regExecPkg::regAddr_t readReg1,
    input  regExecPkg::regAddr_t readReg2,
    input  regExecPkg::regAddr_t writeReg,
    input  regExecPkg::word_t    writeData,
    input  logic                 regWrite,
    output regExecPkg::word_t    readData1,
    output regExecPkg::word_t    readData2
);

    import regExecPkg::*;

    word_t registers [REG_COUNT];

    // Registers 0 and 1 are hardwired constants on the read side
    function automatic word_t readPort(regAddr_t addr);
        word_t value;
        if (addr == REG_ZERO) begin
            value = 32'd0;
        end else if (addr == REG_ONE) begin
            value = 32'd1;
        end else begin
            value = registers[addr];
        end
        return value;
    endfunction

    assign readData1 = readPort(readReg1);
    assign readData2 = readPort(readReg2);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int idx = 0; idx < REG_COUNT; idx++) begin
                registers[idx] <= '0;
            end
        end else if (regWrite && writeReg != REG_ZERO && writeReg != REG_ONE) begin
            registers[writeReg] <= writeData;    // Constant registers never written
        end
    end

endmodule

`default_nettype wire

//--- hdl/regExecPkg.sv
`default_nettype none

package regExecPkg;

    localparam int REG_COUNT = 32;             // Architectural registers
    localparam logic [4:0] REG_ZERO = 5'd0;    // Always reads zero
    localparam logic [4:0] REG_ONE = 5'd1;     // Always reads one

    typedef logic [4:0] regAddr_t;
    typedef logic [31:0] word_t;

    // Major opcodes, standard MIPS values
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_LUI   = 6'h0F
    } opcode_t;

    // R-type function field
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_XOR = 6'h26,
        FN_SLT = 6'h2A
    } funct_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } aluOp_t;

    typedef struct packed {
        opcode_t  op;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
        logic [4:0] shamt;
        funct_t   funct;
    } rType_t;

    typedef struct packed {
        opcode_t  op;
        regAddr_t rs;
        regAddr_t rt;
        logic [15:0] imm;
    } iType_t;

    // Same 32 bits seen as R-type or I-type
    typedef union packed {
        rType_t r;
        iType_t i;
    } instrWord_t;

    typedef struct packed {
        aluOp_t   aluOp;
        logic     useImm;     // Second operand from imm
        word_t    imm;        // Already extended
        regAddr_t dest;
        logic     writeEn;
        logic     illegal;
    } ctrl_t;

endpackage

`default_nettype wire
